/* hdl/lsu_macros.svh */
`ifndef LSU_MACROS_SVH
`define LSU_MACROS_SVH

// width of one data word and of the bus address
`define LSU_DATA_W 32

// word-address bits of the data RAM, 256 words
`define LSU_RAM_AW 8

// entries in the result FIFO between mem stage and writeback
`define LSU_FIFO_DEPTH 4

// register file index width
`define LSU_REG_AW 5

`endif

/* hdl/lsu_op_pkg.sv */
`include "lsu_macros.svh"

package lsu_op_pkg;

    // memory opcode carried from execute
    typedef enum logic [3:0] {
        OP_ALU   = 4'd0,
        OP_LD_B  = 4'd1,
        OP_LD_BU = 4'd2,
        OP_LD_H  = 4'd3,
        OP_LD_HU = 4'd4,
        OP_LD_W  = 4'd5,
        OP_ST_B  = 4'd6,
        OP_ST_H  = 4'd7,
        OP_ST_W  = 4'd8,
        OP_LL_W  = 4'd9,
        OP_SC_W  = 4'd10
    } mem_op_e;

    // execute-to-memory request
    typedef struct packed {
        mem_op_e                op;
        // address, or the ALU result for OP_ALU
        logic [`LSU_DATA_W-1:0] addr;
        logic [`LSU_DATA_W-1:0] wdata;
        logic [`LSU_REG_AW-1:0] wreg_index;
        logic                   wreg_en;
    } mem_req_t;

endpackage

/* hdl/lsu_bus_pkg.sv */
`include "lsu_macros.svh"

package lsu_bus_pkg;

    // wishbone classic master outputs
    typedef struct packed {
        logic                   cyc;
        logic                   stb;
        logic                   we;
        logic [3:0]             sel;
        logic [`LSU_DATA_W-1:0] adr;
        logic [`LSU_DATA_W-1:0] dat;
    } wb_m2s_t;

    // wishbone classic slave outputs
    typedef struct packed {
        logic                   ack;
        logic [`LSU_DATA_W-1:0] dat;
    } wb_s2m_t;

    // finished result on its way to the register file
    typedef struct packed {
        logic [`LSU_REG_AW-1:0] wreg_index;
        logic                   wreg_en;
        logic [`LSU_DATA_W-1:0] data;
    } wb_result_t;

endpackage

/* hdl/mem_stage.sv */
`timescale 1ns/1ns
`include "lsu_macros.svh"

module mem_stage (
    input  logic                    clk,
    input  logic                    reset_i,
    input  logic                    req_valid_i,
    output logic                    req_ready_o,
    input  lsu_op_pkg::mem_req_t    req_i,
    output lsu_bus_pkg::wb_m2s_t    wb_o,
    input  lsu_bus_pkg::wb_s2m_t    wb_i,
    output logic                    push_valid_o,
    input  logic                    push_ready_i,
    output lsu_bus_pkg::wb_result_t push_o
);
    import lsu_op_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        BUS,
        DONE
    } state_e;

    state_e                 state_q;
    mem_req_t               req_q;
    logic                   link_q;
    logic [`LSU_DATA_W-1:0] result_q;

    logic                   accept;
    logic                   needs_bus;
    logic                   is_store_q;
    logic [3:0]             st_sel;
    logic [`LSU_DATA_W-1:0] st_dat;
    logic [7:0]             ld_byte;
    logic [15:0]            ld_half;
    logic [`LSU_DATA_W-1:0] ld_data;

    assign req_ready_o = (state_q == IDLE);
    assign accept      = req_valid_i & req_ready_o;

    // ALU results and a failing SC skip the bus
    assign needs_bus = (req_i.op != OP_ALU) && !((req_i.op == OP_SC_W) && !link_q);

    assign is_store_q = (req_q.op == OP_ST_B) || (req_q.op == OP_ST_H) || (req_q.op == OP_ST_W);

    // store lane placement
    always_comb begin
        st_sel = 4'b1111;
        st_dat = req_q.wdata;
        case (req_q.op)
            OP_ST_B: begin
                st_dat = {4{req_q.wdata[7:0]}};
                st_sel = 4'b0001 << req_q.addr[1:0];
            end
            OP_ST_H: begin
                st_dat = {2{req_q.wdata[15:0]}};
                st_sel = req_q.addr[1] ? 4'b1100 : 4'b0011;
            end
            default: begin
                st_sel = 4'b1111;
                st_dat = req_q.wdata;
            end
        endcase
    end

    // pick the addressed byte and halfword out of the ack data
    always_comb begin
        case (req_q.addr[1:0])
            2'd0:    ld_byte = wb_i.dat[7:0];
            2'd1:    ld_byte = wb_i.dat[15:8];
            2'd2:    ld_byte = wb_i.dat[23:16];
            default: ld_byte = wb_i.dat[31:24];
        endcase
        ld_half = req_q.addr[1] ? wb_i.dat[31:16] : wb_i.dat[15:0];
    end

    always_comb begin
        case (req_q.op)
            OP_LD_B:  ld_data = {{24{ld_byte[7]}}, ld_byte};
            OP_LD_BU: ld_data = {24'h0, ld_byte};
            OP_LD_H:  ld_data = {{16{ld_half[15]}}, ld_half};
            OP_LD_HU: ld_data = {16'h0, ld_half};
            default:  ld_data = wb_i.dat;
        endcase
    end

    // master fields come straight from the held request
    always_comb begin
        wb_o.cyc = (state_q == BUS);
        wb_o.stb = (state_q == BUS);
        wb_o.we  = is_store_q || (req_q.op == OP_SC_W);
        wb_o.sel = st_sel;
        wb_o.adr = req_q.addr;
        wb_o.dat = st_dat;
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q <= IDLE;
            link_q  <= 1'b0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (accept) begin
                        // any SC consumes the link, pass or fail
                        if (req_i.op == OP_SC_W) begin
                            link_q <= 1'b0;
                        end
                        state_q <= needs_bus ? BUS : DONE;
                    end
                end
                BUS: begin
                    if (wb_i.ack) begin
                        if (req_q.op == OP_LL_W) begin
                            link_q <= 1'b1;
                        end
                        state_q <= DONE;
                    end
                end
                DONE: begin
                    if (push_ready_i) begin
                        state_q <= IDLE;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_q    <= req_i;
            // SC that fails here returns 0
            result_q <= (req_i.op == OP_ALU) ? req_i.addr : '0;
        end else if ((state_q == BUS) && wb_i.ack) begin
            result_q <= (req_q.op == OP_SC_W) ? `LSU_DATA_W'd1 : ld_data;
        end
    end

    assign push_valid_o      = (state_q == DONE);
    assign push_o.wreg_index = req_q.wreg_index;
    // plain stores never write a register
    assign push_o.wreg_en    = req_q.wreg_en & ~is_store_q;
    assign push_o.data       = result_q;

endmodule

/* hdl/data_ram.sv */
`timescale 1ns/1ns
`include "lsu_macros.svh"

module data_ram (
    input  logic                 clk,
    input  logic                 reset_i,
    input  lsu_bus_pkg::wb_m2s_t wb_i,
    output lsu_bus_pkg::wb_s2m_t wb_o
);
    localparam int unsigned WORDS = 1 << `LSU_RAM_AW;

    logic [`LSU_DATA_W-1:0] mem [WORDS];
    logic [`LSU_RAM_AW-1:0] word_idx;
    logic                   access;
    logic                   ack_q;
    logic [`LSU_DATA_W-1:0] rdat_q;

    // word index, upper address bits ignored
    assign word_idx = wb_i.adr[`LSU_RAM_AW+1:2];

    // a new access is one not already being acked
    assign access = wb_i.cyc & wb_i.stb & ~ack_q;

    initial begin
        for (int i = 0; i < WORDS; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= access;
        end
    end

    always @(posedge clk) begin
        if (access) begin
            if (wb_i.we) begin
                for (int b = 0; b < 4; b++) begin
                    if (wb_i.sel[b]) begin
                        mem[word_idx][8*b +: 8] <= wb_i.dat[8*b +: 8];
                    end
                end
            end
            rdat_q <= mem[word_idx];
        end
    end

    assign wb_o.ack = ack_q;
    assign wb_o.dat = rdat_q;

endmodule

/* hdl/result_fifo.sv */
`timescale 1ns/1ns
`include "lsu_macros.svh"

module result_fifo (
    input  logic                    clk,
    input  logic                    reset_i,
    input  logic                    push_valid_i,
    output logic                    push_ready_o,
    input  lsu_bus_pkg::wb_result_t push_i,
    output logic                    pop_valid_o,
    input  logic                    pop_ready_i,
    output lsu_bus_pkg::wb_result_t pop_o
);
    import lsu_bus_pkg::*;

    localparam int unsigned DEPTH = `LSU_FIFO_DEPTH;
    localparam int unsigned PW    = $clog2(DEPTH);

    wb_result_t    buf_q [DEPTH];
    logic [PW-1:0] wr_ptr_q;
    logic [PW-1:0] rd_ptr_q;
    logic [PW:0]   count_q;
    logic          full;
    logic          do_push;
    logic          do_pop;

    assign full         = (count_q == (PW+1)'(DEPTH));
    // full FIFO still takes a push when the head leaves in the same cycle
    assign push_ready_o = ~full | pop_ready_i;
    assign pop_valid_o  = (count_q != '0);
    assign do_push      = push_valid_i & push_ready_o;
    assign do_pop       = pop_valid_o & pop_ready_i;
    assign pop_o        = buf_q[rd_ptr_q];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= (wr_ptr_q == PW'(DEPTH-1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= (rd_ptr_q == PW'(DEPTH-1)) ? '0 : rd_ptr_q + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            buf_q[wr_ptr_q] <= push_i;
        end
    end

endmodule

/* hdl/reg_writeback.sv */
`timescale 1ns/1ns
`include "lsu_macros.svh"

module reg_writeback (
    input  logic                    clk,
    input  logic                    reset_i,
    input  logic                    stall_i,
    input  logic                    pop_valid_i,
    output logic                    pop_ready_o,
    input  lsu_bus_pkg::wb_result_t pop_i,
    output logic                    commit_valid_o,
    output logic [`LSU_REG_AW-1:0]  commit_index_o,
    output logic [`LSU_DATA_W-1:0]  commit_data_o,
    input  logic [`LSU_REG_AW-1:0]  rd_index_i,
    output logic [`LSU_DATA_W-1:0]  rd_data_o
);
    localparam int unsigned NREGS = 1 << `LSU_REG_AW;

    logic [`LSU_DATA_W-1:0] regs_q [NREGS];
    logic                   do_pop;
    logic                   commit_valid_q;
    logic [`LSU_REG_AW-1:0] commit_index_q;
    logic [`LSU_DATA_W-1:0] commit_data_q;

    assign pop_ready_o = ~stall_i;
    assign do_pop      = pop_valid_i & pop_ready_o;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            commit_valid_q <= 1'b0;
            for (int i = 0; i < NREGS; i++) begin
                regs_q[i] <= '0;
            end
        end else begin
            commit_valid_q <= do_pop & pop_i.wreg_en;
            // r0 is hardwired, never written
            if (do_pop && pop_i.wreg_en && (pop_i.wreg_index != '0)) begin
                regs_q[pop_i.wreg_index] <= pop_i.data;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_pop) begin
            commit_index_q <= pop_i.wreg_index;
            commit_data_q  <= pop_i.data;
        end
    end

    assign commit_valid_o = commit_valid_q;
    assign commit_index_o = commit_index_q;
    assign commit_data_o  = commit_data_q;

    assign rd_data_o = (rd_index_i == '0) ? '0 : regs_q[rd_index_i];

endmodule

/* hdl/lsu_top.sv */
`timescale 1ns/1ns
`include "lsu_macros.svh"

module lsu_top (
    input  logic                   clk,
    input  logic                   reset_i,
    input  logic                   req_valid_i,
    output logic                   req_ready_o,
    input  lsu_op_pkg::mem_req_t   req_i,
    input  logic                   stall_i,
    output logic                   commit_valid_o,
    output logic [`LSU_REG_AW-1:0] commit_index_o,
    output logic [`LSU_DATA_W-1:0] commit_data_o,
    input  logic [`LSU_REG_AW-1:0] rd_index_i,
    output logic [`LSU_DATA_W-1:0] rd_data_o
);
    import lsu_bus_pkg::*;

    wb_m2s_t    wb_m2s;
    wb_s2m_t    wb_s2m;
    logic       push_valid;
    logic       push_ready;
    wb_result_t push_data;
    logic       pop_valid;
    logic       pop_ready;
    wb_result_t pop_data;

    mem_stage u_mem_stage (
        .clk          (clk),
        .reset_i      (reset_i),
        .req_valid_i  (req_valid_i),
        .req_ready_o  (req_ready_o),
        .req_i        (req_i),
        .wb_o         (wb_m2s),
        .wb_i         (wb_s2m),
        .push_valid_o (push_valid),
        .push_ready_i (push_ready),
        .push_o       (push_data)
    );

    data_ram u_data_ram (
        .clk     (clk),
        .reset_i (reset_i),
        .wb_i    (wb_m2s),
        .wb_o    (wb_s2m)
    );

    result_fifo u_result_fifo (
        .clk          (clk),
        .reset_i      (reset_i),
        .push_valid_i (push_valid),
        .push_ready_o (push_ready),
        .push_i       (push_data),
        .pop_valid_o  (pop_valid),
        .pop_ready_i  (pop_ready),
        .pop_o        (pop_data)
    );

    reg_writeback u_reg_writeback (
        .clk            (clk),
        .reset_i        (reset_i),
        .stall_i        (stall_i),
        .pop_valid_i    (pop_valid),
        .pop_ready_o    (pop_ready),
        .pop_i          (pop_data),
        .commit_valid_o (commit_valid_o),
        .commit_index_o (commit_index_o),
        .commit_data_o  (commit_data_o),
        .rd_index_i     (rd_index_i),
        .rd_data_o      (rd_data_o)
    );

endmodule

/* tb/lsu_tb.sv */
`timescale 1ns/1ns
`include "lsu_macros.svh"

module lsu_tb;
    import lsu_op_pkg::*;
    import lsu_bus_pkg::*;

    localparam int NUM_REQS       = 400;
    localparam int TIMEOUT_CYCLES = NUM_REQS * 10 + 200;
    localparam int MODEL_WORDS    = 32;
    localparam int NREGS          = 1 << `LSU_REG_AW;

    logic                   clk;
    logic                   reset_i;
    logic                   req_valid_i;
    logic                   req_ready_o;
    mem_req_t               req_i;
    logic                   stall_i;
    logic                   commit_valid_o;
    logic [`LSU_REG_AW-1:0] commit_index_o;
    logic [`LSU_DATA_W-1:0] commit_data_o;
    logic [`LSU_REG_AW-1:0] rd_index_i;
    logic [`LSU_DATA_W-1:0] rd_data_o;

    // reference model state
    logic [`LSU_DATA_W-1:0] ref_mem [MODEL_WORDS];
    logic [`LSU_DATA_W-1:0] model_regs [NREGS];
    logic                   model_link;
    wb_result_t             exp_q [$];

    integer seed;
    int     issued;
    int     xfer_count;
    int     cycle_count;

    lsu_top u_lsu_top (
        .clk            (clk),
        .reset_i        (reset_i),
        .req_valid_i    (req_valid_i),
        .req_ready_o    (req_ready_o),
        .req_i          (req_i),
        .stall_i        (stall_i),
        .commit_valid_o (commit_valid_o),
        .commit_index_o (commit_index_o),
        .commit_data_o  (commit_data_o),
        .rd_index_i     (rd_index_i),
        .rd_data_o      (rd_data_o)
    );

    always #10 clk = ~clk;

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Result: FAILED");
        $fatal(1, "simulation stopped on first error");
    endtask

    // aligned addresses within the first 32 words
    function automatic mem_req_t make_request();
        mem_req_t    r;
        logic [31:0] rnd;
        logic [4:0]  word;
        logic [1:0]  lane;
        int unsigned pick;
        pick         = {$random(seed)} % 14;
        rnd          = $random(seed);
        word         = rnd[4:0];
        lane         = rnd[9:8];
        r.wreg_index = rnd[20:16];
        r.wreg_en    = (rnd[26:24] != 3'd0);
        r.wdata      = $random(seed);
        case (pick)
            11:      r.op = OP_LL_W;
            12:      r.op = OP_SC_W;
            13:      r.op = OP_ST_W;
            default: r.op = mem_op_e'(pick[3:0]);
        endcase
        case (r.op)
            OP_ALU:                     r.addr = $random(seed);
            OP_LD_B, OP_LD_BU, OP_ST_B: r.addr = {25'h0, word, lane};
            OP_LD_H, OP_LD_HU, OP_ST_H: r.addr = {25'h0, word, lane[1], 1'b0};
            default:                    r.addr = {25'h0, word, 2'b00};
        endcase
        return r;
    endfunction

    task automatic apply_to_model(input mem_req_t r);
        logic [4:0]             w;
        logic [`LSU_DATA_W-1:0] cur;
        logic [7:0]             b;
        logic [15:0]            h;
        wb_result_t             res;
        w              = r.addr[6:2];
        cur            = ref_mem[w];
        b              = cur[8*r.addr[1:0] +: 8];
        h              = cur[16*r.addr[1] +: 16];
        res.wreg_index = r.wreg_index;
        res.wreg_en    = r.wreg_en;
        res.data       = '0;
        case (r.op)
            OP_ALU:   res.data = r.addr;
            OP_LD_B:  res.data = {{24{b[7]}}, b};
            OP_LD_BU: res.data = {24'h0, b};
            OP_LD_H:  res.data = {{16{h[15]}}, h};
            OP_LD_HU: res.data = {16'h0, h};
            OP_LD_W:  res.data = cur;
            OP_LL_W: begin
                res.data   = cur;
                model_link = 1'b1;
            end
            OP_SC_W: begin
                if (model_link) begin
                    ref_mem[w] = r.wdata;
                    res.data   = 32'd1;
                end
                model_link = 1'b0;
            end
            OP_ST_B: begin
                ref_mem[w][8*r.addr[1:0] +: 8] = r.wdata[7:0];
                res.wreg_en = 1'b0;
            end
            OP_ST_H: begin
                ref_mem[w][16*r.addr[1] +: 16] = r.wdata[15:0];
                res.wreg_en = 1'b0;
            end
            default: begin
                ref_mem[w]  = r.wdata;
                res.wreg_en = 1'b0;
            end
        endcase
        if (res.wreg_en) begin
            exp_q.push_back(res);
            // r0 stays zero
            if (res.wreg_index != '0) begin
                model_regs[res.wreg_index] = res.data;
            end
        end
    endtask

    task automatic check_commit();
        wb_result_t exp;
        assert (exp_q.size() != 0)
            else stop_run("commit_valid_o pulsed while no result was outstanding");
        exp = exp_q.pop_front();
        assert (commit_index_o == exp.wreg_index)
            else stop_run($sformatf("MISMATCH commit_index_o: got %02h expected %02h",
                                    commit_index_o, exp.wreg_index));
        assert (commit_data_o == exp.data)
            else stop_run($sformatf("MISMATCH commit_data_o: got %08h expected %08h",
                                    commit_data_o, exp.data));
    endtask

    // commits and request transfers seen at the rising edge
    always @(posedge clk) begin
        if (!reset_i) begin
            if (commit_valid_o) begin
                check_commit();
            end
            if (req_valid_i && req_ready_o) begin
                apply_to_model(req_i);
                xfer_count++;
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            stop_run($sformatf("timeout, the run did not finish within %0d cycles",
                               TIMEOUT_CYCLES));
        end
    end

    initial begin
        seed        = 32'h4f39_16fd;
        clk         = 1'b0;
        reset_i     = 1'b1;
        req_valid_i = 1'b0;
        req_i       = '0;
        stall_i     = 1'b0;
        rd_index_i  = '0;
        model_link  = 1'b0;
        issued      = 0;
        xfer_count  = 0;
        cycle_count = 0;
        for (int i = 0; i < MODEL_WORDS; i++) begin
            ref_mem[i] = '0;
        end
        for (int i = 0; i < NREGS; i++) begin
            model_regs[i] = '0;
        end

        repeat (3) @(posedge clk);
        @(negedge clk);
        reset_i = 1'b0;

        // hold each request until its transfer amid random gaps and stalls
        while (issued < NUM_REQS || req_valid_i) begin
            @(negedge clk);
            stall_i = (($random(seed) & 3) == 0);
            if (req_valid_i && xfer_count == issued) begin
                req_valid_i = 1'b0;
            end
            if (!req_valid_i && issued < NUM_REQS && (($random(seed) & 7) != 0)) begin
                req_i       = make_request();
                req_valid_i = 1'b1;
                issued++;
            end
        end

        // drain
        @(negedge clk);
        stall_i = 1'b0;
        while (!req_ready_o) begin
            @(negedge clk);
        end
        // unstalled fifo empties one entry per cycle, commit follows a cycle later
        repeat (`LSU_FIFO_DEPTH + 2) @(negedge clk);

        assert (exp_q.size() == 0)
            else stop_run("expected commits were still outstanding at the end");

        for (int i = 0; i < NREGS; i++) begin
            @(negedge clk);
            rd_index_i = i[`LSU_REG_AW-1:0];
            @(posedge clk);
            assert (rd_data_o == model_regs[i])
                else stop_run($sformatf("MISMATCH rd_data_o[r%0d]: got %08h expected %08h",
                                        i, rd_data_o, model_regs[i]));
        end

        $display("Result: PASSED");
        $finish;
    end

endmodule

/* flist.f */
+incdir+hdl
hdl/lsu_op_pkg.sv
hdl/lsu_bus_pkg.sv
hdl/mem_stage.sv
hdl/data_ram.sv
hdl/result_fifo.sv
hdl/reg_writeback.sv
hdl/lsu_top.sv
tb/lsu_tb.sv

/* Bender.yml */
package:
  name: lsu

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/lsu_op_pkg.sv
      - hdl/lsu_bus_pkg.sv
      - hdl/mem_stage.sv
      - hdl/data_ram.sv
      - hdl/result_fifo.sv
      - hdl/reg_writeback.sv
      - hdl/lsu_top.sv
  - target: simulation
    include_dirs:
      - hdl
    files:
      - tb/lsu_tb.sv
